//--- src/cache_subsys_pkg.sv
`default_nettype none

package cache_subsys_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_OFS_W = 4;
  localparam int LINE_W     = ADDR_W - LINE_OFS_W;
  localparam int NUM_PF     = 2;
  localparam int PF_IDX_W   = (NUM_PF > 1) ? $clog2(NUM_PF) : 1;
  localparam int NUM_SNOOP  = 2;
  localparam int CFG_W      = 64;
  localparam int SID_W      = 2;

  // Base word layout
  localparam int BASE_EN_BIT   = 0;
  localparam int BASE_LINE_LSB = LINE_OFS_W;

  // Parameter word layout, stride counted in lines
  localparam int PARAM_FIELD_W    = 16;
  localparam int PARAM_STRIDE_LSB = 0;
  localparam int PARAM_NBLK_LSB   = 16;

  // Status word layout
  localparam int STATUS_BUSY_LSB = 0;
  localparam int STATUS_EN_LSB   = 16;

  typedef enum logic [SID_W-1:0] {
    SRC_LOAD  = 2'd0,
    SRC_STORE = 2'd1,
    SRC_PF    = 2'd2
  } src_id_e;

  typedef enum logic [1:0] {
    OP_LOAD     = 2'd0,
    OP_STORE    = 2'd1,
    OP_PREFETCH = 2'd2
  } mem_op_e;

  typedef enum logic {
    PF_IDLE  = 1'b0,
    PF_ISSUE = 1'b1
  } pf_state_e;

endpackage

`default_nettype wire

//--- src/core_req_port.sv
`default_nettype none

module core_req_port
  import cache_subsys_pkg::*;
#(
  parameter mem_op_e PortOp = OP_LOAD
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              req_valid_i,
  input  wire logic [ADDR_W-1:0] req_addr_i,
  input  wire logic [DATA_W-1:0] req_wdata_i,
  output logic                   req_ready_o,
  output logic                   out_valid_o,
  output logic      [ADDR_W-1:0] out_addr_o,
  output logic      [DATA_W-1:0] out_wdata_o,
  output mem_op_e                out_op_o,
  input  wire logic              out_ready_i,
  output logic                   snoop_valid_o,
  output logic      [LINE_W-1:0] snoop_line_o
);

  logic              full_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic              accept;

  // Empty or draining this cycle
  assign req_ready_o = !full_q || out_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
  end

  assign out_valid_o = full_q;
  assign out_addr_o  = addr_q;
  assign out_wdata_o = wdata_q;
  assign out_op_o    = PortOp;

  // Prefetcher sees every accepted request
  assign snoop_valid_o = accept;
  assign snoop_line_o  = req_addr_i[ADDR_W-1:LINE_OFS_W];

  a_out_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_addr_o)
  ) else $error("core_req_port: request changed under back-pressure");

endmodule

`default_nettype wire

//--- src/stride_prefetcher.sv
`default_nettype none

module stride_prefetcher
  import cache_subsys_pkg::*;
(
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            base_set_i,
  input  wire logic [CFG_W-1:0]                base_i,
  input  wire logic                            param_set_i,
  input  wire logic [CFG_W-1:0]                param_i,
  input  wire logic [NUM_SNOOP-1:0]            snoop_valid_i,
  input  wire logic [NUM_SNOOP-1:0][LINE_W-1:0] snoop_line_i,
  input  wire logic                            issue_ready_i,
  output logic      [CFG_W-1:0]                base_o,
  output logic      [CFG_W-1:0]                param_o,
  output logic                                 busy_o,
  output logic                                 issue_valid_o,
  output logic      [ADDR_W-1:0]               issue_addr_o
);

  pf_state_e                state_q;
  logic [CFG_W-1:0]         base_q;
  logic [CFG_W-1:0]         param_q;
  logic [PARAM_FIELD_W-1:0] cnt_q;
  logic [LINE_W-1:0]        cur_line_q;

  logic [LINE_W-1:0]        base_line;
  logic [PARAM_FIELD_W-1:0] stride;
  logic [PARAM_FIELD_W-1:0] nblk;
  logic [LINE_W-1:0]        next_line;
  logic                     hit;
  logic                     start;
  logic                     issue_done;
  logic                     last;

  assign base_line = base_q[ADDR_W-1:BASE_LINE_LSB];
  assign stride    = param_q[PARAM_STRIDE_LSB +: PARAM_FIELD_W];
  assign nblk      = param_q[PARAM_NBLK_LSB +: PARAM_FIELD_W];
  assign next_line = cur_line_q + LINE_W'(stride);

  always_comb begin
    hit = 1'b0;
    for (int s = 0; s < NUM_SNOOP; s++) begin
      if (snoop_valid_i[s] && (snoop_line_i[s] == base_line)) begin
        hit = 1'b1;
      end
    end
  end

  // Snoops only matter while idle
  assign start = (state_q == PF_IDLE) && base_q[BASE_EN_BIT] && (nblk != '0) && hit
                 && !base_set_i;
  assign issue_done = issue_valid_o && issue_ready_i;
  assign last       = (cnt_q == PARAM_FIELD_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PF_IDLE;
      base_q  <= '0;
      param_q <= '0;
      cnt_q   <= '0;
    end else begin
      if (param_set_i) begin
        param_q <= param_i;
      end
      if (base_set_i) begin
        // Writing the base aborts any burst
        base_q  <= base_i;
        state_q <= PF_IDLE;
      end else if (start) begin
        state_q <= PF_ISSUE;
        cnt_q   <= nblk;
      end else if (issue_done) begin
        if (last) begin
          state_q                           <= PF_IDLE;
          base_q[ADDR_W-1:BASE_LINE_LSB]    <= cur_line_q;
        end else begin
          cnt_q <= cnt_q - PARAM_FIELD_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      cur_line_q <= base_line + LINE_W'(stride);
    end else if (issue_done) begin
      cur_line_q <= next_line;
    end
  end

  assign base_o        = base_q;
  assign param_o       = param_q;
  assign busy_o        = (state_q == PF_ISSUE);
  assign issue_valid_o = busy_o;
  assign issue_addr_o  = {cur_line_q, {LINE_OFS_W{1'b0}}};

  // A pending issue holds its address until taken or aborted
  a_issue_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ready_i && !base_set_i
      |=> issue_valid_o && $stable(issue_addr_o)
  ) else $error("stride_prefetcher: issue dropped or changed while stalled");

endmodule

`default_nettype wire

//--- src/hwpf_engine.sv
`default_nettype none

module hwpf_engine
  import cache_subsys_pkg::*;
(
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic [NUM_PF-1:0]                pf_base_set_i,
  input  wire logic [NUM_PF-1:0][CFG_W-1:0]     pf_base_i,
  input  wire logic [NUM_PF-1:0]                pf_param_set_i,
  input  wire logic [NUM_PF-1:0][CFG_W-1:0]     pf_param_i,
  output logic      [NUM_PF-1:0][CFG_W-1:0]     pf_base_o,
  output logic      [NUM_PF-1:0][CFG_W-1:0]     pf_param_o,
  output logic      [CFG_W-1:0]                 pf_status_o,
  input  wire logic [NUM_SNOOP-1:0]             snoop_valid_i,
  input  wire logic [NUM_SNOOP-1:0][LINE_W-1:0] snoop_line_i,
  output logic                                  pf_valid_o,
  output logic      [ADDR_W-1:0]                pf_addr_o,
  input  wire logic                             pf_ready_i
);

  logic [NUM_PF-1:0]             req;
  logic [NUM_PF-1:0]             gnt;
  logic [NUM_PF-1:0]             busy;
  logic [NUM_PF-1:0][ADDR_W-1:0] issue_addr;
  logic [PF_IDX_W-1:0]           ptr_q;
  logic [PF_IDX_W-1:0]           gnt_idx;

  for (genvar i = 0; i < NUM_PF; i++) begin : gen_pf
    stride_prefetcher i_stride_prefetcher (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .base_set_i    (pf_base_set_i[i]),
      .base_i        (pf_base_i[i]),
      .param_set_i   (pf_param_set_i[i]),
      .param_i       (pf_param_i[i]),
      .snoop_valid_i (snoop_valid_i),
      .snoop_line_i  (snoop_line_i),
      .issue_ready_i (gnt[i] && pf_ready_i),
      .base_o        (pf_base_o[i]),
      .param_o       (pf_param_o[i]),
      .busy_o        (busy[i]),
      .issue_valid_o (req[i]),
      .issue_addr_o  (issue_addr[i])
    );
  end

  // Round robin, nearest requester at or after the pointer wins
  always_comb begin
    int unsigned idx;
    gnt     = '0;
    gnt_idx = ptr_q;
    for (int i = NUM_PF - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % NUM_PF;
      if (req[idx]) begin
        gnt_idx = PF_IDX_W'(idx);
      end
    end
    if (req[gnt_idx]) begin
      gnt[gnt_idx] = 1'b1;
    end
  end

  // A stalled grant parks the pointer on itself so the channel holds
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (pf_valid_o) begin
      if (!pf_ready_i) begin
        ptr_q <= gnt_idx;
      end else if (gnt_idx == PF_IDX_W'(NUM_PF - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= gnt_idx + PF_IDX_W'(1);
      end
    end
  end

  assign pf_valid_o = |req;
  assign pf_addr_o  = issue_addr[gnt_idx];

  always_comb begin
    pf_status_o = '0;
    for (int i = 0; i < NUM_PF; i++) begin
      pf_status_o[STATUS_BUSY_LSB + i] = busy[i];
      pf_status_o[STATUS_EN_LSB + i]   = pf_base_o[i][BASE_EN_BIT];
    end
  end

  a_gnt_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pf_valid_o |-> $onehot(gnt)
  ) else $error("hwpf_engine: grant not one-hot");

endmodule

`default_nettype wire

//--- src/mem_port_mux.sv
`default_nettype none

module mem_port_mux
  import cache_subsys_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              ld_valid_i,
  input  wire logic [ADDR_W-1:0] ld_addr_i,
  input  mem_op_e                ld_op_i,
  output logic                   ld_ready_o,
  input  wire logic              st_valid_i,
  input  wire logic [ADDR_W-1:0] st_addr_i,
  input  wire logic [DATA_W-1:0] st_wdata_i,
  input  mem_op_e                st_op_i,
  output logic                   st_ready_o,
  input  wire logic              pf_valid_i,
  input  wire logic [ADDR_W-1:0] pf_addr_i,
  output logic                   pf_ready_o,
  output logic                   mem_req_valid_o,
  output logic      [ADDR_W-1:0] mem_req_addr_o,
  output mem_op_e                mem_req_op_o,
  output logic      [DATA_W-1:0] mem_req_wdata_o,
  output logic      [SID_W-1:0]  mem_req_sid_o,
  input  wire logic              mem_req_ready_i,
  input  wire logic              mem_rsp_valid_i,
  input  wire logic [SID_W-1:0]  mem_rsp_sid_i,
  input  wire logic [DATA_W-1:0] mem_rsp_data_i,
  output logic                   load_rsp_valid_o,
  output logic      [DATA_W-1:0] load_rsp_data_o,
  output logic                   store_rsp_valid_o
);

  logic [2:0] req_vec;
  src_id_e    sel_src;
  src_id_e    lock_src_q;
  logic       lock_q;

  assign req_vec = {pf_valid_i, st_valid_i, ld_valid_i};

  // Fixed priority, except a stalled transfer keeps its source
  always_comb begin
    if (lock_q && req_vec[lock_src_q]) begin
      sel_src = lock_src_q;
    end else if (ld_valid_i) begin
      sel_src = SRC_LOAD;
    end else if (st_valid_i) begin
      sel_src = SRC_STORE;
    end else begin
      sel_src = SRC_PF;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q     <= 1'b0;
      lock_src_q <= SRC_LOAD;
    end else begin
      lock_q     <= mem_req_valid_o && !mem_req_ready_i;
      lock_src_q <= sel_src;
    end
  end

  assign mem_req_valid_o = |req_vec;
  assign mem_req_sid_o   = sel_src;

  always_comb begin
    case (sel_src)
      SRC_LOAD: begin
        mem_req_addr_o  = ld_addr_i;
        mem_req_op_o    = ld_op_i;
        mem_req_wdata_o = '0;
      end
      SRC_STORE: begin
        mem_req_addr_o  = st_addr_i;
        mem_req_op_o    = st_op_i;
        mem_req_wdata_o = st_wdata_i;
      end
      default: begin
        mem_req_addr_o  = pf_addr_i;
        mem_req_op_o    = OP_PREFETCH;
        mem_req_wdata_o = '0;
      end
    endcase
  end

  assign ld_ready_o = mem_req_ready_i && (sel_src == SRC_LOAD);
  assign st_ready_o = mem_req_ready_i && (sel_src == SRC_STORE);
  assign pf_ready_o = mem_req_ready_i && (sel_src == SRC_PF);

  // Prefetch responses end here
  assign load_rsp_valid_o  = mem_rsp_valid_i && (mem_rsp_sid_i == SRC_LOAD);
  assign load_rsp_data_o   = mem_rsp_data_i;
  assign store_rsp_valid_o = mem_rsp_valid_i && (mem_rsp_sid_i == SRC_STORE);

  a_rsp_sid_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_valid_i |-> mem_rsp_sid_i inside {SRC_LOAD, SRC_STORE, SRC_PF}
  ) else $error("mem_port_mux: response with unknown sid %0d", mem_rsp_sid_i);

endmodule

`default_nettype wire

//--- src/cache_subsys_top.sv
`default_nettype none

module cache_subsys_top
  import cache_subsys_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         load_req_valid_i,
  input  wire logic [ADDR_W-1:0]            load_req_addr_i,
  output logic                              load_req_ready_o,
  output logic                              load_rsp_valid_o,
  output logic      [DATA_W-1:0]            load_rsp_data_o,
  input  wire logic                         store_req_valid_i,
  input  wire logic [ADDR_W-1:0]            store_req_addr_i,
  input  wire logic [DATA_W-1:0]            store_req_wdata_i,
  output logic                              store_req_ready_o,
  output logic                              store_rsp_valid_o,
  input  wire logic [NUM_PF-1:0]            pf_base_set_i,
  input  wire logic [NUM_PF-1:0][CFG_W-1:0] pf_base_i,
  input  wire logic [NUM_PF-1:0]            pf_param_set_i,
  input  wire logic [NUM_PF-1:0][CFG_W-1:0] pf_param_i,
  output logic      [NUM_PF-1:0][CFG_W-1:0] pf_base_o,
  output logic      [NUM_PF-1:0][CFG_W-1:0] pf_param_o,
  output logic      [CFG_W-1:0]             pf_status_o,
  output logic                              mem_req_valid_o,
  output logic      [ADDR_W-1:0]            mem_req_addr_o,
  output mem_op_e                           mem_req_op_o,
  output logic      [DATA_W-1:0]            mem_req_wdata_o,
  output logic      [SID_W-1:0]             mem_req_sid_o,
  input  wire logic                         mem_req_ready_i,
  input  wire logic                         mem_rsp_valid_i,
  input  wire logic [SID_W-1:0]             mem_rsp_sid_i,
  input  wire logic [DATA_W-1:0]            mem_rsp_data_i
);

  logic                             ld_valid;
  logic [ADDR_W-1:0]                ld_addr;
  mem_op_e                          ld_op;
  logic                             ld_ready;
  logic                             st_valid;
  logic [ADDR_W-1:0]                st_addr;
  logic [DATA_W-1:0]                st_wdata;
  mem_op_e                          st_op;
  logic                             st_ready;
  logic                             pf_valid;
  logic [ADDR_W-1:0]                pf_addr;
  logic                             pf_ready;
  logic [NUM_SNOOP-1:0]             snoop_valid;
  logic [NUM_SNOOP-1:0][LINE_W-1:0] snoop_line;

  // Loads carry no write data
  core_req_port #(
    .PortOp (OP_LOAD)
  ) i_load_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (load_req_valid_i),
    .req_addr_i    (load_req_addr_i),
    .req_wdata_i   ('0),
    .req_ready_o   (load_req_ready_o),
    .out_valid_o   (ld_valid),
    .out_addr_o    (ld_addr),
    .out_wdata_o   (),
    .out_op_o      (ld_op),
    .out_ready_i   (ld_ready),
    .snoop_valid_o (snoop_valid[0]),
    .snoop_line_o  (snoop_line[0])
  );

  core_req_port #(
    .PortOp (OP_STORE)
  ) i_store_port (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (store_req_valid_i),
    .req_addr_i    (store_req_addr_i),
    .req_wdata_i   (store_req_wdata_i),
    .req_ready_o   (store_req_ready_o),
    .out_valid_o   (st_valid),
    .out_addr_o    (st_addr),
    .out_wdata_o   (st_wdata),
    .out_op_o      (st_op),
    .out_ready_i   (st_ready),
    .snoop_valid_o (snoop_valid[1]),
    .snoop_line_o  (snoop_line[1])
  );

  hwpf_engine i_hwpf_engine (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pf_base_set_i  (pf_base_set_i),
    .pf_base_i      (pf_base_i),
    .pf_param_set_i (pf_param_set_i),
    .pf_param_i     (pf_param_i),
    .pf_base_o      (pf_base_o),
    .pf_param_o     (pf_param_o),
    .pf_status_o    (pf_status_o),
    .snoop_valid_i  (snoop_valid),
    .snoop_line_i   (snoop_line),
    .pf_valid_o     (pf_valid),
    .pf_addr_o      (pf_addr),
    .pf_ready_i     (pf_ready)
  );

  mem_port_mux i_mem_port_mux (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ld_valid_i        (ld_valid),
    .ld_addr_i         (ld_addr),
    .ld_op_i           (ld_op),
    .ld_ready_o        (ld_ready),
    .st_valid_i        (st_valid),
    .st_addr_i         (st_addr),
    .st_wdata_i        (st_wdata),
    .st_op_i           (st_op),
    .st_ready_o        (st_ready),
    .pf_valid_i        (pf_valid),
    .pf_addr_i         (pf_addr),
    .pf_ready_o        (pf_ready),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_req_addr_o    (mem_req_addr_o),
    .mem_req_op_o      (mem_req_op_o),
    .mem_req_wdata_o   (mem_req_wdata_o),
    .mem_req_sid_o     (mem_req_sid_o),
    .mem_req_ready_i   (mem_req_ready_i),
    .mem_rsp_valid_i   (mem_rsp_valid_i),
    .mem_rsp_sid_i     (mem_rsp_sid_i),
    .mem_rsp_data_i    (mem_rsp_data_i),
    .load_rsp_valid_o  (load_rsp_valid_o),
    .load_rsp_data_o   (load_rsp_data_o),
    .store_rsp_valid_o (store_rsp_valid_o)
  );

endmodule

`default_nettype wire

//--- verif/tb_cache_subsys.sv
`default_nettype none

module tb_cache_subsys
  import cache_subsys_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int N_RAND       = 40;
  localparam int N_REQ        = 2 * N_RAND + 16;
  localparam int REQ_BUDGET   = 200;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             load_req_valid_i;
  logic [ADDR_W-1:0]                load_req_addr_i;
  logic                             load_req_ready_o;
  logic                             load_rsp_valid_o;
  logic [DATA_W-1:0]                load_rsp_data_o;
  logic                             store_req_valid_i;
  logic [ADDR_W-1:0]                store_req_addr_i;
  logic [DATA_W-1:0]                store_req_wdata_i;
  logic                             store_req_ready_o;
  logic                             store_rsp_valid_o;
  logic [NUM_PF-1:0]                pf_base_set_i;
  logic [NUM_PF-1:0][CFG_W-1:0]     pf_base_i;
  logic [NUM_PF-1:0]                pf_param_set_i;
  logic [NUM_PF-1:0][CFG_W-1:0]     pf_param_i;
  logic [NUM_PF-1:0][CFG_W-1:0]     pf_base_o;
  logic [NUM_PF-1:0][CFG_W-1:0]     pf_param_o;
  logic [CFG_W-1:0]                 pf_status_o;
  logic                             mem_req_valid_o;
  logic [ADDR_W-1:0]                mem_req_addr_o;
  mem_op_e                          mem_req_op_o;
  logic [DATA_W-1:0]                mem_req_wdata_o;
  logic [SID_W-1:0]                 mem_req_sid_o;
  logic                             mem_req_ready_i;
  logic                             mem_rsp_valid_i;
  logic [SID_W-1:0]                 mem_rsp_sid_i;
  logic [DATA_W-1:0]                mem_rsp_data_i;

  integer seed = 15972;
  int     ld_cnt = 0;
  int     ld_rsp_cnt = 0;

  // Handshakes captured at the rising edge
  logic              ld_acc_q = 1'b0;
  logic [ADDR_W-1:0] ld_acc_addr_q;
  logic              st_acc_q = 1'b0;
  logic [ADDR_W-1:0] st_acc_addr_q;
  logic [DATA_W-1:0] st_acc_wdata_q;
  logic              mem_acc_q = 1'b0;
  logic [SID_W-1:0]  mem_sid_q;
  logic [ADDR_W-1:0] mem_addr_q;
  mem_op_e           mem_op_q;
  logic              ld_rsp_seen_q = 1'b0;

  // Scoreboard queues and their heads
  logic [ADDR_W-1:0] ld_q[$];
  logic [ADDR_W-1:0] st_addr_q[$];
  logic [DATA_W-1:0] st_wdata_q[$];
  logic [ADDR_W-1:0] pf_q[$];
  logic [ADDR_W-1:0] ld_rsp_q[$];
  logic              have_ld = 1'b0;
  logic              have_st = 1'b0;
  logic              have_pf = 1'b0;
  logic              have_ld_rsp = 1'b0;
  logic [ADDR_W-1:0] exp_ld_addr = '0;
  logic [ADDR_W-1:0] exp_st_addr = '0;
  logic [DATA_W-1:0] exp_st_wdata = '0;
  logic [ADDR_W-1:0] exp_pf_addr = '0;
  logic [DATA_W-1:0] exp_ld_data = '0;

  // Prefetcher model
  logic [CFG_W-1:0]  mdl_base  [NUM_PF];
  logic [CFG_W-1:0]  mdl_param [NUM_PF];

  logic              mem_fire;

  assign mem_fire = mem_req_valid_o && mem_req_ready_i;

  cache_subsys_top dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .load_req_valid_i  (load_req_valid_i),
    .load_req_addr_i   (load_req_addr_i),
    .load_req_ready_o  (load_req_ready_o),
    .load_rsp_valid_o  (load_rsp_valid_o),
    .load_rsp_data_o   (load_rsp_data_o),
    .store_req_valid_i (store_req_valid_i),
    .store_req_addr_i  (store_req_addr_i),
    .store_req_wdata_i (store_req_wdata_i),
    .store_req_ready_o (store_req_ready_o),
    .store_rsp_valid_o (store_rsp_valid_o),
    .pf_base_set_i     (pf_base_set_i),
    .pf_base_i         (pf_base_i),
    .pf_param_set_i    (pf_param_set_i),
    .pf_param_i        (pf_param_i),
    .pf_base_o         (pf_base_o),
    .pf_param_o        (pf_param_o),
    .pf_status_o       (pf_status_o),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_req_addr_o    (mem_req_addr_o),
    .mem_req_op_o      (mem_req_op_o),
    .mem_req_wdata_o   (mem_req_wdata_o),
    .mem_req_sid_o     (mem_req_sid_o),
    .mem_req_ready_i   (mem_req_ready_i),
    .mem_rsp_valid_i   (mem_rsp_valid_i),
    .mem_rsp_sid_i     (mem_rsp_sid_i),
    .mem_rsp_data_i    (mem_rsp_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  // Expected prefetch burst for a snooped line
  task automatic model_snoop(input logic [LINE_W-1:0] line);
    logic [LINE_W-1:0]        base_line;
    logic [PARAM_FIELD_W-1:0] stride;
    logic [PARAM_FIELD_W-1:0] nblk;
    for (int i = 0; i < NUM_PF; i++) begin
      base_line = mdl_base[i][ADDR_W-1:LINE_OFS_W];
      stride    = mdl_param[i][PARAM_STRIDE_LSB +: PARAM_FIELD_W];
      nblk      = mdl_param[i][PARAM_NBLK_LSB +: PARAM_FIELD_W];
      if (mdl_base[i][BASE_EN_BIT] && nblk != '0 && line == base_line) begin
        for (int k = 1; k <= int'(nblk); k++) begin
          pf_q.push_back({base_line + LINE_W'(k * int'(stride)), {LINE_OFS_W{1'b0}}});
        end
        mdl_base[i][ADDR_W-1:LINE_OFS_W] = base_line + LINE_W'(int'(nblk) * int'(stride));
      end
    end
  endtask

  always @(posedge clk_i) begin
    ld_acc_q       <= load_req_valid_i && load_req_ready_o;
    ld_acc_addr_q  <= load_req_addr_i;
    st_acc_q       <= store_req_valid_i && store_req_ready_o;
    st_acc_addr_q  <= store_req_addr_i;
    st_acc_wdata_q <= store_req_wdata_i;
    mem_acc_q      <= mem_fire;
    mem_sid_q      <= mem_req_sid_o;
    mem_addr_q     <= mem_req_addr_o;
    mem_op_q       <= mem_req_op_o;
    ld_rsp_seen_q  <= load_rsp_valid_o;
    if (load_rsp_valid_o) begin
      ld_rsp_cnt <= ld_rsp_cnt + 1;
    end
  end

  // Scoreboard update, memory model and stalls
  always @(negedge clk_i) begin
    if (ld_rsp_seen_q && ld_rsp_q.size() != 0) begin
      void'(ld_rsp_q.pop_front());
    end
    if (ld_acc_q) begin
      ld_q.push_back(ld_acc_addr_q);
      ld_rsp_q.push_back(ld_acc_addr_q);
      ld_cnt++;
      model_snoop(ld_acc_addr_q[ADDR_W-1:LINE_OFS_W]);
    end
    if (st_acc_q) begin
      st_addr_q.push_back(st_acc_addr_q);
      st_wdata_q.push_back(st_acc_wdata_q);
      model_snoop(st_acc_addr_q[ADDR_W-1:LINE_OFS_W]);
    end
    if (mem_acc_q) begin
      if (mem_sid_q == SRC_LOAD && ld_q.size() != 0) begin
        void'(ld_q.pop_front());
      end else if (mem_sid_q == SRC_STORE && st_addr_q.size() != 0) begin
        void'(st_addr_q.pop_front());
        void'(st_wdata_q.pop_front());
      end else if (mem_sid_q == SRC_PF && pf_q.size() != 0) begin
        void'(pf_q.pop_front());
      end
    end
    mem_rsp_valid_i = mem_acc_q;
    mem_rsp_sid_i   = mem_sid_q;
    mem_rsp_data_i  = (mem_acc_q && mem_op_q != OP_STORE) ? mem_addr_q[DATA_W-1:0] : '0;
    mem_req_ready_i = (($random(seed) & 3) != 0);
    have_ld      = (ld_q.size() != 0);
    exp_ld_addr  = have_ld ? ld_q[0] : '0;
    have_st      = (st_addr_q.size() != 0);
    exp_st_addr  = have_st ? st_addr_q[0] : '0;
    exp_st_wdata = have_st ? st_wdata_q[0] : '0;
    have_pf      = (pf_q.size() != 0);
    exp_pf_addr  = have_pf ? pf_q[0] : '0;
    // Memory returns the low address bits as load data
    have_ld_rsp  = (ld_rsp_q.size() != 0);
    exp_ld_data  = have_ld_rsp ? ld_rsp_q[0][DATA_W-1:0] : '0;
  end

  a_reset_state : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !mem_req_valid_o && !load_rsp_valid_o && !store_rsp_valid_o
      && pf_status_o == '0 && pf_base_o == '0 && pf_param_o == '0
  ) else fail_now("Outputs not in their reset state after reset");

  a_mem_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
      && $stable(mem_req_op_o) && $stable(mem_req_sid_o) && $stable(mem_req_wdata_o)
  ) else fail_now("Memory request dropped or changed while stalled");

  a_sid_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o |-> mem_req_sid_o inside {SRC_LOAD, SRC_STORE, SRC_PF}
  ) else fail_now($sformatf("Fail mem_req_sid_o: got %h", $sampled(mem_req_sid_o)));

  a_ld_expected : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_fire && mem_req_sid_o == SRC_LOAD |-> have_ld && mem_req_op_o == OP_LOAD
  ) else fail_now("Load request on memory side without a matching accepted load");

  a_ld_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_fire && mem_req_sid_o == SRC_LOAD |-> mem_req_addr_o == exp_ld_addr
  ) else fail_now($sformatf("Fail mem_req_addr_o: got %h expected %h",
                            $sampled(mem_req_addr_o), exp_ld_addr));

  a_st_expected : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_fire && mem_req_sid_o == SRC_STORE |-> have_st && mem_req_op_o == OP_STORE
  ) else fail_now("Store request on memory side without a matching accepted store");

  a_st_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_fire && mem_req_sid_o == SRC_STORE |-> mem_req_addr_o == exp_st_addr
  ) else fail_now($sformatf("Fail mem_req_addr_o: got %h expected %h",
                            $sampled(mem_req_addr_o), exp_st_addr));

  a_st_wdata : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_fire && mem_req_sid_o == SRC_STORE |-> mem_req_wdata_o == exp_st_wdata
  ) else fail_now($sformatf("Fail mem_req_wdata_o: got %h expected %h",
                            $sampled(mem_req_wdata_o), exp_st_wdata));

  a_pf_expected : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_fire && mem_req_sid_o == SRC_PF |-> have_pf && mem_req_op_o == OP_PREFETCH
      && pf_status_o[STATUS_BUSY_LSB +: NUM_PF] != '0
  ) else fail_now("Prefetch request that no enabled prefetcher should issue");

  a_pf_addr : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_fire && mem_req_sid_o == SRC_PF |-> mem_req_addr_o == exp_pf_addr
  ) else fail_now($sformatf("Fail mem_req_addr_o: got %h expected %h",
                            $sampled(mem_req_addr_o), exp_pf_addr));

  a_ld_rsp : assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_rsp_valid_o == (mem_rsp_valid_i && mem_rsp_sid_i == SRC_LOAD)
      && store_rsp_valid_o == (mem_rsp_valid_i && mem_rsp_sid_i == SRC_STORE)
  ) else fail_now("Response routed to the wrong port");

  a_ld_rsp_data : assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_rsp_valid_o |-> have_ld_rsp && load_rsp_data_o == exp_ld_data
  ) else fail_now($sformatf("Fail load_rsp_data_o: got %h expected %h",
                            $sampled(load_rsp_data_o), exp_ld_data));

  a_en_bits : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pf_status_o[STATUS_EN_LSB +: NUM_PF]
      == {mdl_base[1][BASE_EN_BIT], mdl_base[0][BASE_EN_BIT]}
  ) else fail_now($sformatf("Fail pf_status_o: got %h expected enable bits %h",
                            $sampled(pf_status_o),
                            {mdl_base[1][BASE_EN_BIT], mdl_base[0][BASE_EN_BIT]}));

  task automatic send_load(input logic [ADDR_W-1:0] addr);
    load_req_valid_i = 1'b1;
    load_req_addr_i  = addr;
    do @(negedge clk_i); while (!ld_acc_q);
    load_req_valid_i = 1'b0;
  endtask

  task automatic send_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    store_req_valid_i = 1'b1;
    store_req_addr_i  = addr;
    store_req_wdata_i = wdata;
    do @(negedge clk_i); while (!st_acc_q);
    store_req_valid_i = 1'b0;
  endtask

  task automatic write_base(input int idx, input logic [CFG_W-1:0] val);
    pf_base_set_i[idx] = 1'b1;
    pf_base_i[idx]     = val;
    @(negedge clk_i);
    pf_base_set_i[idx] = 1'b0;
    mdl_base[idx]      = val;
    assert (pf_base_o[idx] == val)
      else fail_now($sformatf("Fail pf_base_o[%0d]: got %h expected %h", idx, pf_base_o[idx], val));
  endtask

  task automatic write_param(input int idx, input logic [CFG_W-1:0] val);
    pf_param_set_i[idx] = 1'b1;
    pf_param_i[idx]     = val;
    @(negedge clk_i);
    pf_param_set_i[idx] = 1'b0;
    mdl_param[idx]      = val;
    assert (pf_param_o[idx] == val)
      else fail_now($sformatf("Fail pf_param_o[%0d]: got %h expected %h", idx, pf_param_o[idx], val));
  endtask

  // Queue heads only change on falling edges
  task automatic wait_idle();
    do @(posedge clk_i); while (have_ld || have_st || have_pf);
    @(negedge clk_i);
  endtask

  task automatic check_base(input int idx);
    assert (pf_base_o[idx] == mdl_base[idx])
      else fail_now($sformatf("Fail pf_base_o[%0d]: got %h expected %h",
                              idx, pf_base_o[idx], mdl_base[idx]));
    assert (pf_status_o[STATUS_BUSY_LSB +: NUM_PF] == '0)
      else fail_now($sformatf("Fail pf_status_o: got %h with no burst pending", pf_status_o));
  endtask

  initial begin
    repeat (RESET_CYCLES + REQ_BUDGET * N_REQ) @(posedge clk_i);
    $display("Timeout: requests still pending after the cycle budget");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin
    integer            r;
    logic [ADDR_W-1:0] la;
    logic [ADDR_W-1:0] sa;
    logic [DATA_W-1:0] sw;
    rst_ni            = 1'b0;
    load_req_valid_i  = 1'b0;
    load_req_addr_i   = '0;
    store_req_valid_i = 1'b0;
    store_req_addr_i  = '0;
    store_req_wdata_i = '0;
    pf_base_set_i     = '0;
    pf_base_i         = '0;
    pf_param_set_i    = '0;
    pf_param_i        = '0;
    mem_req_ready_i   = 1'b0;
    mem_rsp_valid_i   = 1'b0;
    mem_rsp_sid_i     = '0;
    mem_rsp_data_i    = '0;
    for (int i = 0; i < NUM_PF; i++) begin
      mdl_base[i]  = '0;
      mdl_param[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Mixed traffic, prefetchers still disabled
    for (int n = 0; n < N_RAND; n++) begin
      r  = $random(seed);
      la = $random(seed);
      sa = $random(seed);
      sw = $random(seed);
      if (r[1:0] == 2'b00) begin
        @(negedge clk_i);
      end
      fork
        begin
          if (r[0]) send_load(la);
        end
        begin
          if (r[1]) send_store(sa, sw);
        end
      join
    end
    wait_idle();

    // Prefetcher 0, stride 3 lines, 4 blocks from line 0x100
    write_param(0, 64'h0000_0000_0004_0003);
    write_base(0, 64'h0000_0000_0000_1001);
    send_load(32'h0000_1004);
    wait_idle();
    check_base(0);

    // Prefetcher 1 triggered by a store
    write_param(1, 64'h0000_0000_0002_0001);
    write_base(1, 64'h0000_0000_0002_0001);
    send_store(32'h0002_0008, 32'hcafe_0001);
    wait_idle();
    check_base(1);

    // Other line, then a disabled prefetcher
    send_load(32'h0000_5000);
    write_base(0, 64'h0000_0000_0000_10c0);
    send_load(32'h0000_10c0);
    wait_idle();
    check_base(0);
    repeat (4) @(negedge clk_i);
    assert (ld_rsp_cnt == ld_cnt)
      else fail_now($sformatf("Fail load_rsp_valid_o count: got %h expected %h", ld_rsp_cnt, ld_cnt));

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/cache_subsys_pkg.sv
src/core_req_port.sv
src/stride_prefetcher.sv
src/hwpf_engine.sv
src/mem_port_mux.sv
src/cache_subsys_top.sv
verif/tb_cache_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_subsys
RTL_TOP   ?= cache_subsys_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
LINT_OPTS ?= --lint-only -Wall --timing
SIM_OPTS  ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(TOP) -f $(FILELIST)

$(EXE): $(FILELIST) $(SRCS)
	$(VERILATOR) $(SIM_OPTS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(EXE)
	-$(EXE) 2>&1 | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
